// ==== rtl/sys_macros.svh ====
`ifndef SYS_MACROS_SVH
`define SYS_MACROS_SVH

// Array depths as word-address widths
`define SRAM_AW 14
`define ROM_AW  10
`define VID_AW  11 // 4 KB text buffer

// Memory map, upper address nibble / byte
`define PAGE_ROM_LO 4'hC
`define PAGE_ROM_HI 4'hF
`define VID_BASE    8'hB8

// Flash programming ports
`define PORT_FADR 16'hE000 // Address register
`define PORT_FDAT 16'hE002 // Data window

// Post-code range F100..F1FF
`define POST_HI 8'hF1

`endif

// ==== rtl/wb_pkg.sv ====
package wb_pkg;

  // Classic Wishbone request, master to target
  typedef struct packed {
    logic [19:1] adr;  // Word address
    logic [15:0] dat;  // Write data
    logic [1:0]  sel;  // Byte lanes
    logic        we;
    logic        tga;  // High for I/O space
    logic        stb;
    logic        cyc;
  } wb_req_t;

  // Target response
  typedef struct packed {
    logic [15:0] dat;  // Read data, valid with ack
    logic        ack;
  } wb_rsp_t;

endpackage

// ==== rtl/map_pkg.sv ====
package map_pkg;

  // Memory space view of the word address
  typedef struct packed {
    logic [3:0]  page;    // 64 KB page
    logic [3:0]  sub;     // 4 KB block within the page
    logic [10:0] offset;  // Word within the block
  } mem_view_t;

  // I/O space view, 16-bit port space
  typedef struct packed {
    logic [3:0]  rsvd;
    logic [14:0] port;    // Byte port without bit 0
  } io_view_t;

  // Same 19 bits, read one way or the other depending on tga
  typedef union packed {
    mem_view_t mem;
    io_view_t  io;
  } adr_view_u;

  typedef enum logic [2:0] {
    SRAM,
    FLASH,
    VIDEO,
    POST,
    NONE
  } tgt_e;

endpackage

// ==== rtl/bus_decoder.sv ====
`include "sys_macros.svh"

module bus_decoder (
  input  logic              clk,
  input  logic              arst_n_i,
  input  wb_pkg::wb_req_t   m_req_i,
  output wb_pkg::wb_rsp_t   m_rsp_o,
  output wb_pkg::wb_req_t   sram_req_o,
  output wb_pkg::wb_req_t   flash_req_o,
  output wb_pkg::wb_req_t   vid_req_o,
  input  wb_pkg::wb_rsp_t   sram_rsp_i,
  input  wb_pkg::wb_rsp_t   flash_rsp_i,
  input  wb_pkg::wb_rsp_t   vid_rsp_i
);

  import wb_pkg::*;
  import map_pkg::*;

  adr_view_u   av;
  tgt_e        tgt;
  wb_req_t     idle_req;  // Request with strobes removed
  logic        m_act;
  logic        post_wr;
  logic [15:0] post_q;

  assign av    = m_req_i.adr;
  assign m_act = m_req_i.stb & m_req_i.cyc;

  // Target select from address and cycle type
  always_comb begin
    if (!m_req_i.tga) begin
      if (av.mem.page == `PAGE_ROM_LO || av.mem.page == `PAGE_ROM_HI) begin
        tgt = FLASH;
      end else if ({av.mem.page, av.mem.sub} == `VID_BASE) begin
        tgt = VIDEO;
      end else begin
        tgt = SRAM;
      end
    end else begin
      if ({av.io.port, 1'b0} == `PORT_FADR || {av.io.port, 1'b0} == `PORT_FDAT) begin
        tgt = FLASH;
      end else if (av.io.port[14:7] == `POST_HI) begin
        tgt = POST;
      end else begin
        tgt = NONE;
      end
    end
  end

  always_comb begin
    idle_req     = m_req_i;
    idle_req.stb = 1'b0;
    idle_req.cyc = 1'b0;
  end

  // Address and data go everywhere, strobes only to the selected target
  assign sram_req_o  = (tgt == SRAM)  ? m_req_i : idle_req;
  assign flash_req_o = (tgt == FLASH) ? m_req_i : idle_req;
  assign vid_req_o   = (tgt == VIDEO) ? m_req_i : idle_req;

  assign post_wr = (tgt == POST) & m_act & m_req_i.we;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      post_q <= 16'h0000;
    end else if (post_wr) begin
      if (m_req_i.sel[0]) post_q[7:0]  <= m_req_i.dat[7:0];
      if (m_req_i.sel[1]) post_q[15:8] <= m_req_i.dat[15:8];
    end
  end

  // Response mux, POST and NONE answer in the same cycle
  always_comb begin
    case (tgt)
      SRAM:    m_rsp_o = sram_rsp_i;
      FLASH:   m_rsp_o = flash_rsp_i;
      VIDEO:   m_rsp_o = vid_rsp_i;
      POST: begin
        m_rsp_o.dat = post_q;
        m_rsp_o.ack = m_act;
      end
      default: begin
        m_rsp_o.dat = 16'h0000;  // Unmapped I/O reads as zero
        m_rsp_o.ack = m_act;
      end
    endcase
  end

  // At most one target answers at a time
  a_one_target: assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0({sram_rsp_i.ack, flash_rsp_i.ack, vid_rsp_i.ack}));

  // Registered target acks must still find the master strobing
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_rsp_o.ack |-> m_req_i.stb);

endmodule

// ==== rtl/sram_ctrl.sv ====
`include "sys_macros.svh"

module sram_ctrl (
  input  logic            clk,
  input  logic            arst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  logic [15:0]         mem [0:(1 << `SRAM_AW) - 1];
  logic [`SRAM_AW-1:0] waddr;
  logic                xfer;
  logic                ack_q;
  logic [15:0]         rdat_q;

  assign waddr = req_i.adr[`SRAM_AW:1];  // Upper bits wrap

  // New transfer, not while acking the previous one
  assign xfer = req_i.stb & req_i.cyc & ~ack_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= xfer;
    end
  end

  // Byte-lane writes
  always_ff @(posedge clk) begin
    if (xfer && req_i.we) begin
      if (req_i.sel[0]) mem[waddr][7:0]  <= req_i.dat[7:0];
      if (req_i.sel[1]) mem[waddr][15:8] <= req_i.dat[15:8];
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      rdat_q <= mem[waddr];
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

  // Ack only while the master still holds the request
  a_ack_in_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    rsp_o.ack |-> req_i.stb && req_i.cyc);

endmodule

// ==== rtl/flash_ctrl.sv ====
`include "sys_macros.svh"

module flash_ctrl (
  input  logic            clk,
  input  logic            arst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  logic [15:0]        rom [0:(1 << `ROM_AW) - 1];
  logic [`ROM_AW-1:0] mem_idx;
  logic [`ROM_AW-1:0] prg_idx;
  logic [15:0]        fadr_q;   // Programming address
  logic               xfer;
  logic               dat_port; // E002 when set, E000 otherwise
  logic               io_wr;
  logic               ack_q;
  logic [15:0]        rdat_q;

  assign xfer     = req_i.stb & req_i.cyc & ~ack_q;
  assign dat_port = req_i.adr[1];
  assign io_wr    = xfer & req_i.tga & req_i.we;
  assign mem_idx  = req_i.adr[`ROM_AW:1];
  assign prg_idx  = fadr_q[`ROM_AW-1:0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q  <= 1'b0;
      fadr_q <= 16'h0000;
    end else begin
      ack_q <= xfer;
      if (io_wr) begin
        if (dat_port) fadr_q <= fadr_q + 16'd1;  // Auto-increment on data write
        else          fadr_q <= req_i.dat;
      end
    end
  end

  // Array is written only through the data port
  always_ff @(posedge clk) begin
    if (io_wr && dat_port) begin
      rom[prg_idx] <= req_i.dat;
    end
  end

  // Memory-space writes fall through here, acked and ignored
  always_ff @(posedge clk) begin
    if (xfer && !req_i.we) begin
      if (!req_i.tga) begin
        rdat_q <= rom[mem_idx];
      end else if (dat_port) begin
        rdat_q <= rom[prg_idx];  // No increment on read
      end else begin
        rdat_q <= fadr_q;
      end
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

endmodule

// ==== rtl/video_ram.sv ====
`include "sys_macros.svh"

module video_ram (
  input  logic            clk,
  input  logic            arst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  logic [15:0]        vmem [0:(1 << `VID_AW) - 1];
  logic [`VID_AW-1:0] vaddr;
  logic               req_act;
  logic [1:0]         ack_sr;  // Stand-in for the display clock crossing
  logic [15:0]        rdat_q;

  assign vaddr   = req_i.adr[`VID_AW:1];
  assign req_act = req_i.stb & req_i.cyc;

  // Stage 0 fires once per transfer, stage 1 is the ack
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_sr <= 2'b00;
    end else begin
      ack_sr[0] <= req_act & ~ack_sr[0] & ~ack_sr[1];
      ack_sr[1] <= ack_sr[0] & ~ack_sr[1];
    end
  end

  // Access happens in the middle cycle, fields are still held
  always_ff @(posedge clk) begin
    if (ack_sr[0] && req_act && req_i.we) begin
      if (req_i.sel[0]) vmem[vaddr][7:0]  <= req_i.dat[7:0];
      if (req_i.sel[1]) vmem[vaddr][15:8] <= req_i.dat[15:8];
    end
  end

  always_ff @(posedge clk) begin
    if (ack_sr[0]) begin
      rdat_q <= vmem[vaddr];
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_sr[1];

  // Ack only while the master still holds the request
  a_ack_in_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    rsp_o.ack |-> req_act);

endmodule

// ==== rtl/bus_subsys_top.sv ====
module bus_subsys_top (
  input  logic            clk,
  input  logic            arst_n_i,
  input  wb_pkg::wb_req_t m_req_i,
  output wb_pkg::wb_rsp_t m_rsp_o
);

  import wb_pkg::*;

  wb_req_t sram_req;
  wb_req_t flash_req;
  wb_req_t vid_req;
  wb_rsp_t sram_rsp;
  wb_rsp_t flash_rsp;
  wb_rsp_t vid_rsp;

  bus_decoder u_dec (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .m_req_i     (m_req_i),
    .m_rsp_o     (m_rsp_o),
    .sram_req_o  (sram_req),
    .flash_req_o (flash_req),
    .vid_req_o   (vid_req),
    .sram_rsp_i  (sram_rsp),
    .flash_rsp_i (flash_rsp),
    .vid_rsp_i   (vid_rsp)
  );

  sram_ctrl u_sram (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (sram_req),
    .rsp_o    (sram_rsp)
  );

  flash_ctrl u_flash (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (flash_req),
    .rsp_o    (flash_rsp)
  );

  video_ram u_vid (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (vid_req),
    .rsp_o    (vid_rsp)
  );

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock #(
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  // Released on a falling edge, clear of the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== dv/bus_subsys_tb.sv ====
`include "sys_macros.svh"

module bus_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import wb_pkg::*;

  localparam int   RST_CYCLES  = 3;
  localparam int   ACK_WAIT    = 8;
  localparam int   N_XFER      = 941;  // Transfers over all tests
  localparam int   CYCLE_LIMIT = N_XFER * 10 + RST_CYCLES;
  localparam int   SRAM_WORDS  = 1 << `SRAM_AW;
  localparam int   ROM_WORDS   = 1 << `ROM_AW;
  localparam int   VID_WORDS   = 1 << `VID_AW;
  localparam logic MEM = 1'b0;
  localparam logic IO  = 1'b1;
  localparam logic RD  = 1'b0;
  localparam logic WR  = 1'b1;

  logic    clk;
  logic    arst_n;
  wb_req_t m_req;
  wb_rsp_t m_rsp;

  // Reference model, the *_k arrays mark bytes holding known data
  logic [15:0] sram_m  [SRAM_WORDS];
  logic [1:0]  sram_k  [SRAM_WORDS];
  logic [15:0] flash_m [ROM_WORDS];
  logic [1:0]  flash_k [ROM_WORDS];
  logic [15:0] vid_m   [VID_WORDS];
  logic [1:0]  vid_k   [VID_WORDS];
  logic [15:0] fadr_m;
  logic [15:0] post_m;
  logic [15:0] flash_base;  // First programmed flash word

  integer seed;
  int     err_cnt;
  int     chk_cnt;
  int     test_err;
  int     test_chk;
  int     cycle_cnt = 0;

  tb_clock #(.RST_CYCLES(RST_CYCLES)) u_clk (.clk_o(clk), .arst_n_o(arst_n));

  bus_subsys_top UUT (
    .clk      (clk),
    .arst_n_i (arst_n),
    .m_req_i  (m_req),
    .m_rsp_o  (m_rsp)
  );

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic logic [15:0] lane_mask(input logic [1:0] k);
    lane_mask = {{8{k[1]}}, {8{k[0]}}};
  endfunction

  function automatic logic is_sram_addr(input logic [19:0] a);
    is_sram_addr = !(a[19:16] == `PAGE_ROM_LO || a[19:16] == `PAGE_ROM_HI ||
                     a[19:12] == `VID_BASE);
  endfunction

  function automatic logic [19:0] rand_sram_addr(input logic near);
    logic [31:0] r;
    logic [19:0] a;
    do begin
      r = next_rand();
      a = {r[19:1], 1'b0};
      if (near) a[14:7] = 8'h00;  // Small window, reads hit earlier writes
    end while (!is_sram_addr(a));
    rand_sram_addr = a;
  endfunction

  function automatic logic [19:0] rand_unmapped_port();
    logic [31:0] r;
    logic [15:0] p;
    do begin
      r = next_rand();
      p = {r[15:1], 1'b0};
    end while (p == `PORT_FADR || p == `PORT_FDAT || p[15:8] == `POST_HI);
    rand_unmapped_port = {4'h0, p};
  endfunction

  task automatic check_value(input string name, input logic [19:0] a,
                             input logic [15:0] exp, input logic [15:0] act);
    chk_cnt++;
    test_chk++;
    if (act !== exp) begin
      $display("Error %s: adr %05h expected %04h actual %04h", name, a, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  // Applies one transfer to the model, returns read data and its known bits
  task automatic model_access(input logic [19:0] a, input logic tga, input logic we,
                              input logic [15:0] d, input logic [1:0] sel,
                              output logic [15:0] exp, output logic [15:0] mask);
    logic [15:0]         lanes;
    logic [`SRAM_AW-1:0] si;
    logic [`ROM_AW-1:0]  fi;
    logic [`VID_AW-1:0]  vi;
    lanes = lane_mask(sel);
    si    = a[`SRAM_AW:1];  // Upper bits wrap
    fi    = a[`ROM_AW:1];
    vi    = a[`VID_AW:1];
    exp   = 16'h0000;
    mask  = 16'hFFFF;
    if (!tga) begin
      if (a[19:16] == `PAGE_ROM_LO || a[19:16] == `PAGE_ROM_HI) begin
        if (!we) begin  // Window writes change nothing
          exp  = flash_m[fi];
          mask = lane_mask(flash_k[fi]);
        end
      end else if (a[19:12] == `VID_BASE) begin
        if (we) begin
          vid_m[vi] = (vid_m[vi] & ~lanes) | (d & lanes);
          vid_k[vi] = vid_k[vi] | sel;
        end else begin
          exp  = vid_m[vi];
          mask = lane_mask(vid_k[vi]);
        end
      end else if (we) begin
        sram_m[si] = (sram_m[si] & ~lanes) | (d & lanes);
        sram_k[si] = sram_k[si] | sel;
      end else begin
        exp  = sram_m[si];
        mask = lane_mask(sram_k[si]);
      end
    end else begin
      fi = fadr_m[`ROM_AW-1:0];
      if (a[15:0] == `PORT_FADR) begin
        if (we) fadr_m = d;
        else    exp = fadr_m;
      end else if (a[15:0] == `PORT_FDAT) begin
        if (we) begin
          flash_m[fi] = d;  // Whole word, sel plays no part
          flash_k[fi] = 2'b11;
          fadr_m      = fadr_m + 16'd1;
        end else begin
          exp  = flash_m[fi];
          mask = lane_mask(flash_k[fi]);
        end
      end else if (a[15:8] == `POST_HI) begin
        if (we) post_m = (post_m & ~lanes) | (d & lanes);
        else    exp = post_m;
      end
    end
  endtask

  task automatic bus_xfer(input string name, input logic [19:0] a, input logic tga,
                          input logic we, input logic [15:0] d, input logic [1:0] sel);
    wb_req_t     r;
    logic [15:0] exp;
    logic [15:0] mask;
    logic [15:0] rdat;
    logic        got;
    int          waited;
    r     = '0;
    r.adr = a[19:1];
    r.dat = d;
    r.sel = sel;
    r.we  = we;
    r.tga = tga;
    r.stb = 1'b1;
    r.cyc = 1'b1;
    @(posedge clk);
    m_req  <= r;
    waited = 0;
    @(negedge clk);
    while (!m_rsp.ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    got  = m_rsp.ack;
    rdat = m_rsp.dat;
    @(posedge clk);
    r.stb = 1'b0;
    r.cyc = 1'b0;
    m_req <= r;  // One idle cycle before the next transfer
    model_access(a, tga, we, d, sel, exp, mask);
    if (!got) begin
      $display("%s: no acknowledge within %0d cycles at address %05h", name, ACK_WAIT, a);
      err_cnt++;
      test_err++;
    end else if (!we) begin
      check_value(name, a, exp & mask, rdat & mask);
    end
  endtask

  task automatic begin_test();
    test_err = 0;
    test_chk = 0;
  endtask

  task automatic end_test(input string name);
    $display("%s finished: %0d checks, %0d errors", name, test_chk, test_err);
  endtask

  task automatic run_sram_test();
    logic [31:0] r;
    logic [19:0] a;
    logic [19:0] b;
    begin_test();
    for (int i = 0; i < 200; i++) begin
      a = rand_sram_addr(1'b0);
      do begin
        r = next_rand();
        b = {r[19:15], a[14:0]};  // Same word index, other upper bits
      end while (!is_sram_addr(b));
      r = next_rand();
      bus_xfer("sram", a, MEM, WR, r[15:0], r[17:16]);
      bus_xfer("sram", b, MEM, RD, r[31:16], 2'b11);
    end
    end_test("sram");
  endtask

  task automatic run_video_test();
    logic [31:0] r;
    logic [31:0] w;
    logic [19:0] v;
    logic [19:0] s;
    logic [1:0]  sel;
    begin_test();
    for (int i = 0; i < 24; i++) begin
      r   = next_rand();
      v   = {`VID_BASE, r[11:1], 1'b0};
      s   = {8'h08, r[11:1], 1'b0};  // SRAM word with the same low bits
      sel = (r[13:12] == 2'b00) ? 2'b11 : r[13:12];
      w   = next_rand();
      bus_xfer("video", s, MEM, WR, w[31:16], 2'b11);
      bus_xfer("video", v, MEM, WR, r[31:16], sel);
      bus_xfer("video", v, MEM, RD, 16'h0000, 2'b11);
      bus_xfer("video", s, MEM, RD, 16'h0000, 2'b11);
    end
    end_test("video");
  endtask

  task automatic run_flash_test();
    logic [31:0]        r;
    logic [31:0]        w;
    logic [31:0]        pos;
    logic [`ROM_AW-1:0] idx;
    logic [3:0]         pg;
    begin_test();
    r          = next_rand();
    flash_base = r[15:0];
    bus_xfer("flash", {4'h0, `PORT_FADR}, IO, WR, flash_base, 2'b11);
    for (int i = 0; i < 64; i++) begin
      r = next_rand();
      bus_xfer("flash", {4'h0, `PORT_FDAT}, IO, WR, r[15:0], 2'b11);
    end
    bus_xfer("flash", {4'h0, `PORT_FADR}, IO, RD, 16'h0000, 2'b11);  // Base plus 64
    bus_xfer("flash", {4'h0, `PORT_FADR}, IO, WR, flash_base, 2'b11);
    bus_xfer("flash", {4'h0, `PORT_FDAT}, IO, RD, 16'h0000, 2'b11);
    for (int i = 0; i < 64; i++) begin
      r   = next_rand();
      pos = {16'h0000, flash_base} + i;
      idx = pos[`ROM_AW-1:0];
      pg  = r[0] ? `PAGE_ROM_HI : `PAGE_ROM_LO;
      bus_xfer("flash", {pg, r[15:`ROM_AW+1], idx, 1'b0}, MEM, RD, 16'h0000, 2'b11);
    end
    for (int i = 0; i < 8; i++) begin
      r   = next_rand();
      pos = {16'h0000, flash_base} + {26'h0, r[21:16]};
      idx = pos[`ROM_AW-1:0];
      pg  = r[0] ? `PAGE_ROM_HI : `PAGE_ROM_LO;
      w   = next_rand();
      bus_xfer("flash", {pg, r[15:`ROM_AW+1], idx, 1'b0}, MEM, WR, w[31:16], 2'b11);
      bus_xfer("flash", {pg, r[15:`ROM_AW+1], idx, 1'b0}, MEM, RD, 16'h0000, 2'b11);
    end
    end_test("flash");
  endtask

  task automatic run_post_test();
    logic [31:0] r;
    begin_test();
    r = next_rand();
    bus_xfer("post", {4'h0, `POST_HI, r[7:1], 1'b0}, IO, RD, 16'h0000, 2'b11);
    for (int i = 0; i < 32; i++) begin
      r = next_rand();
      bus_xfer("post", {4'h0, `POST_HI, r[7:1], 1'b0}, IO, WR, r[31:16], r[9:8]);
      bus_xfer("post", {4'h0, `POST_HI, r[15:9], 1'b0}, IO, RD, 16'h0000, 2'b11);
    end
    end_test("post");
  endtask

  task automatic run_unmapped_test();
    begin_test();
    for (int i = 0; i < 32; i++) begin
      bus_xfer("unmapped", rand_unmapped_port(), IO, RD, 16'h0000, 2'b11);
    end
    end_test("unmapped");
  endtask

  task automatic run_mixed_test();
    logic [31:0] r;
    logic [31:0] pos;
    logic [19:0] a;
    logic        tga;
    logic        we;
    begin_test();
    for (int i = 0; i < 200; i++) begin
      r   = next_rand();
      we  = r[3];
      tga = IO;
      pos = {16'h0000, flash_base} + {26'h0, r[9:4]};
      case (r[2:0])
        3'd0, 3'd1: begin
          a   = rand_sram_addr(1'b1);
          tga = MEM;
        end
        3'd2: begin
          a   = {`VID_BASE, 5'b00000, r[9:4], 1'b0};
          tga = MEM;
        end
        3'd3: begin
          a   = {r[10] ? `PAGE_ROM_HI : `PAGE_ROM_LO, r[15:`ROM_AW+1],
                 pos[`ROM_AW-1:0], 1'b0};
          tga = MEM;
        end
        3'd4: begin
          a  = {4'h0, r[4] ? `PORT_FDAT : `PORT_FADR};
          we = we & r[4];  // Address register is only read here
        end
        3'd5:    a = {4'h0, `POST_HI, r[10:4], 1'b0};
        3'd6:    a = rand_unmapped_port();
        default: begin
          a   = rand_sram_addr(1'b0);
          tga = MEM;
        end
      endcase
      bus_xfer("mixed", a, tga, we, r[31:16], r[15:14]);
    end
    end_test("mixed");
  endtask

  initial begin
    seed    = 32'h8e680802;
    err_cnt = 0;
    chk_cnt = 0;
    fadr_m  = 16'h0000;
    post_m  = 16'h0000;
    m_req  <= '0;
    for (int i = 0; i < SRAM_WORDS; i++) begin
      sram_k[i] = 2'b00;
    end
    for (int i = 0; i < ROM_WORDS; i++) begin
      flash_k[i] = 2'b00;
    end
    for (int i = 0; i < VID_WORDS; i++) begin
      vid_k[i] = 2'b00;
    end
    wait (arst_n === 1'b1);
    run_sram_test();
    run_video_test();
    run_flash_test();
    run_post_test();
    run_unmapped_test();
    run_mixed_test();
    $display("Total: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/map_pkg.sv
rtl/bus_decoder.sv
rtl/sram_ctrl.sv
rtl/flash_ctrl.sv
rtl/video_ram.sv
rtl/bus_subsys_top.sv
dv/tb_clock.sv
dv/bus_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module bus_subsys_tb -o sim_bus_subsys

out=$(./obj_dir/sim_bus_subsys) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
